/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = fir_tb
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+source
source/fir_pkg.sv
source/fir_config_regs.sv
source/fir_sample_ring.sv
source/fir_mac_engine.sv
source/fir_top.sv
test/fir_tb_clock.sv
test/fir_tb.sv

/* source/fir_config_regs.sv */
`timescale 1ns/100ps
`include "fir_macros.svh"

module fir_config_regs (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    // write channel
    input  logic                   awvalid,
    output logic                   awready,
    input  fir_pkg::reg_addr_t     awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`FIR_DATA_W-1:0] wdata,
    // read channel
    input  logic                   arvalid,
    output logic                   arready,
    input  fir_pkg::reg_addr_t     araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`FIR_DATA_W-1:0] rdata,
    // engine side
    input  logic                   run_done,
    input  fir_pkg::tap_idx_t      tap_idx,
    output logic                   start,
    output fir_pkg::length_t       data_length,
    output fir_pkg::coef_t         coef
);

    // aligned address inside the coefficient window
    function automatic logic is_tap_addr(input fir_pkg::reg_addr_t addr);
        fir_pkg::reg_addr_t off;
        off = addr - fir_pkg::reg_addr_t'(`FIR_TAP_BASE);
        return (addr >= fir_pkg::reg_addr_t'(`FIR_TAP_BASE))
            && (off % fir_pkg::reg_addr_t'(`FIR_TAP_STRIDE) == '0)
            && (off / fir_pkg::reg_addr_t'(`FIR_TAP_STRIDE)
                < fir_pkg::reg_addr_t'(`FIR_NUM_TAPS));
    endfunction

    // tap number from a byte address
    function automatic fir_pkg::tap_idx_t tap_slot(input fir_pkg::reg_addr_t addr);
        fir_pkg::reg_addr_t off;
        off = (addr - fir_pkg::reg_addr_t'(`FIR_TAP_BASE))
            / fir_pkg::reg_addr_t'(`FIR_TAP_STRIDE);
        return fir_pkg::tap_idx_t'(off);
    endfunction

    logic                   wr_fire;
    logic                   start_acc;
    logic                   wr_len;
    logic                   wr_tap;
    logic                   ap_idle;
    logic                   ap_done;
    logic                   rd_done_seen;
    logic [`FIR_DATA_W-1:0] rd_mux;
    fir_pkg::coef_t         coef_bank [`FIR_NUM_TAPS];

    // ============================================================
    // write decode
    // ============================================================

    // address and data taken together, single beat
    assign wr_fire   = awvalid && wvalid;
    assign awready   = wr_fire;
    assign wready    = wr_fire;
    // start only counts while idle
    assign start_acc = wr_fire && (awaddr == `FIR_REG_CTRL) && wdata[0] && ap_idle;
    // settings frozen during a run
    assign wr_len    = wr_fire && ap_idle && (awaddr == `FIR_REG_LEN);
    assign wr_tap    = wr_fire && ap_idle && is_tap_addr(awaddr);

    // start pulse, idle and done flags
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            start   <= 1'b0;
            ap_idle <= 1'b1;
            ap_done <= 1'b0;
        end else begin
            start <= start_acc;
            if (start_acc) begin
                ap_idle <= 1'b0;
                ap_done <= 1'b0;
            end else if (run_done) begin
                ap_idle <= 1'b1;
                ap_done <= 1'b1;
            end else if (rvalid && rready && rd_done_seen) begin
                // done was returned to the host, drop it
                ap_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
        end else if (wr_len) begin
            data_length <= fir_pkg::length_t'(wdata);
        end
    end

    // coefficient bank
    always_ff @(posedge axis_clk) begin
        if (wr_tap) begin
            coef_bank[tap_slot(awaddr)] <= fir_pkg::coef_t'(wdata);
        end
    end

    // engine lookup, out of range taps give 0
    assign coef = (tap_idx < fir_pkg::tap_idx_t'(`FIR_NUM_TAPS)) ? coef_bank[tap_idx] : '0;

    // ============================================================
    // read path
    // ============================================================

    // one read in flight, write to same address wins
    assign arready = arvalid && !rvalid && !(awvalid && (awaddr == araddr));

    always_comb begin
        rd_mux = '0;
        if (araddr == `FIR_REG_CTRL) begin
            // bit 0 reads back 0, start is only a pulse
            rd_mux = {{(`FIR_DATA_W-3){1'b0}}, ap_idle, ap_done, 1'b0};
        end else if (araddr == `FIR_REG_LEN) begin
            rd_mux = data_length;
        end else if (is_tap_addr(araddr)) begin
            rd_mux = coef_bank[tap_slot(araddr)];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rvalid       <= 1'b0;
            rd_done_seen <= 1'b0;
        end else if (arready) begin
            rvalid       <= 1'b1;
            // remember whether this status read carries done
            rd_done_seen <= (araddr == `FIR_REG_CTRL) && ap_idle && ap_done;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    // data held until the host takes it
    always_ff @(posedge axis_clk) begin
        if (arready) begin
            rdata <= rd_mux;
        end
    end

endmodule

/* source/fir_mac_engine.sv */
`timescale 1ns/100ps
`include "fir_macros.svh"

module fir_mac_engine (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    // from the register block
    input  logic              start,
    input  fir_pkg::length_t  data_length,
    input  fir_pkg::coef_t    coef,
    // input stream
    input  logic              ss_tvalid,
    output logic              ss_tready,
    input  fir_pkg::sample_t  ss_tdata,
    // accepted, run length comes from data_length
    input  logic              ss_tlast,
    // sample history
    output logic              push,
    output fir_pkg::sample_t  push_data,
    input  fir_pkg::sample_t  rd_data,
    // coefficient index and ring lag
    output fir_pkg::tap_idx_t tap_idx,
    // output stream
    output logic              sm_tvalid,
    input  logic              sm_tready,
    output fir_pkg::acc_t     sm_tdata,
    output logic              sm_tlast,
    output logic              run_done
);

    fir_pkg::engine_state_t state;
    fir_pkg::engine_state_t state_nxt;
    fir_pkg::tap_idx_t      tap_cnt;
    fir_pkg::length_t       out_cnt;
    fir_pkg::acc_t          prod;
    fir_pkg::acc_t          acc;
    logic                   prod_vld;
    logic                   in_fire;
    logic                   out_fire;
    logic                   last_tap;
    logic                   is_last;

    // ============================================================
    // handshakes and flags
    // ============================================================

    // one sample per result
    assign ss_tready = (state == fir_pkg::st_wait_in);
    assign in_fire   = ss_tvalid && ss_tready;
    assign push      = in_fire;
    assign push_data = ss_tdata;

    assign last_tap  = (tap_cnt == fir_pkg::tap_idx_t'(`FIR_NUM_TAPS - 1));
    assign tap_idx   = tap_cnt;

    assign out_fire  = sm_tvalid && sm_tready;
    assign is_last   = (out_cnt == data_length - fir_pkg::length_t'(1));
    assign sm_tlast  = sm_tvalid && is_last;
    assign sm_tdata  = acc;
    // end of run seen by the register block
    assign run_done  = out_fire && sm_tlast;

    // ============================================================
    // state machine
    // ============================================================
    always_comb begin
        state_nxt = state;
        case (state)
            fir_pkg::st_idle:    if (start) state_nxt = fir_pkg::st_wait_in;
            fir_pkg::st_wait_in: if (in_fire) state_nxt = fir_pkg::st_mac;
            fir_pkg::st_mac:     if (last_tap) state_nxt = fir_pkg::st_out;
            fir_pkg::st_out: begin
                // stall here while the sink holds off
                if (out_fire) begin
                    state_nxt = sm_tlast ? fir_pkg::st_idle : fir_pkg::st_wait_in;
                end
            end
            default:             state_nxt = fir_pkg::st_idle;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= fir_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // tap counter, sweeps 0..10 then rewinds
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            tap_cnt <= '0;
        end else if (state == fir_pkg::st_mac) begin
            tap_cnt <= last_tap ? '0 : tap_cnt + 1'b1;
        end
    end

    // results sent so far in this run
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            out_cnt <= '0;
        end else if (start) begin
            out_cnt <= '0;
        end else if (out_fire) begin
            out_cnt <= out_cnt + 1'b1;
        end
    end

    // ============================================================
    // multiply-accumulate
    // ============================================================

    // product register, one stage behind the tap counter
    always_ff @(posedge axis_clk) begin
        if (state == fir_pkg::st_mac) begin
            prod <= coef * rd_data;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            prod_vld  <= 1'b0;
            sm_tvalid <= 1'b0;
        end else begin
            prod_vld <= (state == fir_pkg::st_mac);
            // last product lands in the first st_out cycle
            if ((state == fir_pkg::st_out) && prod_vld) begin
                sm_tvalid <= 1'b1;
            end else if (out_fire) begin
                sm_tvalid <= 1'b0;
            end
        end
    end

    // wraps at 32 bits, holds in st_out
    always_ff @(posedge axis_clk) begin
        if (in_fire) begin
            acc <= '0;
        end else if (prod_vld) begin
            acc <= acc + prod;
        end
    end

endmodule

/* source/fir_macros.svh */
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// ============================================================
// datapath sizing
// ============================================================

// sample, coefficient and result width
`define FIR_DATA_W 32
// axi-lite byte address width
`define FIR_ADDR_W 12
// filter order plus one
`define FIR_NUM_TAPS 11

// ============================================================
// register map, byte addresses
// ============================================================

`define FIR_REG_CTRL 12'h000
`define FIR_REG_LEN 12'h010
// tap k lives at base + k * stride
`define FIR_TAP_BASE 12'h020
`define FIR_TAP_STRIDE 4

`endif

/* source/fir_pkg.sv */
`include "fir_macros.svh"

package fir_pkg;

    // ============================================================
    // datapath types
    // ============================================================

    // one input sample from the stream
    typedef logic signed [`FIR_DATA_W-1:0] sample_t;

    // one filter coefficient
    typedef logic signed [`FIR_DATA_W-1:0] coef_t;

    // running sum and output word, wraps on overflow
    typedef logic signed [`FIR_DATA_W-1:0] acc_t;

    // tap number or history lag, 0 to 10
    typedef logic [3:0] tap_idx_t;

    // register port address
    typedef logic [`FIR_ADDR_W-1:0] reg_addr_t;

    // samples per run
    typedef logic [31:0] length_t;

    // ============================================================
    // engine sequencing
    // ============================================================
    typedef enum logic [1:0] {
        st_idle,
        st_wait_in,
        st_mac,
        st_out
    } engine_state_t;

endpackage

/* source/fir_sample_ring.sv */
`timescale 1ns/100ps
`include "fir_macros.svh"

module fir_sample_ring (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              clear,
    input  logic              push,
    input  fir_pkg::sample_t  push_data,
    input  fir_pkg::tap_idx_t rd_lag,
    output fir_pkg::sample_t  rd_data
);

    fir_pkg::sample_t  hist [`FIR_NUM_TAPS];
    // next slot to be written
    fir_pkg::tap_idx_t wr_ptr;
    logic [4:0]        rd_pos_raw;
    fir_pkg::tap_idx_t rd_pos;

    // ============================================================
    // write side
    // ============================================================
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
        end else if (push) begin
            // wrap modulo tap count
            wr_ptr <= (wr_ptr == fir_pkg::tap_idx_t'(`FIR_NUM_TAPS - 1)) ? '0
                                                                          : wr_ptr + 1'b1;
        end
    end

    // new run starts from all-zero history
    always_ff @(posedge axis_clk) begin
        if (clear) begin
            for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (push) begin
            hist[wr_ptr] <= push_data;
        end
    end

    // ============================================================
    // read side
    // ============================================================

    // newest is wr_ptr - 1, step back by lag
    assign rd_pos_raw = {1'b0, wr_ptr} + 5'(`FIR_NUM_TAPS - 1) - {1'b0, rd_lag};
    assign rd_pos     = (rd_pos_raw >= 5'(`FIR_NUM_TAPS))
                      ? fir_pkg::tap_idx_t'(rd_pos_raw - 5'(`FIR_NUM_TAPS))
                      : fir_pkg::tap_idx_t'(rd_pos_raw);
    // lag past the window reads zero
    assign rd_data    = (rd_lag < fir_pkg::tap_idx_t'(`FIR_NUM_TAPS)) ? hist[rd_pos] : '0;

endmodule

/* source/fir_top.sv */
`timescale 1ns/100ps
`include "fir_macros.svh"

module fir_top (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    // ============================================================
    // axi-lite register port
    // ============================================================
    input  logic                   awvalid,
    output logic                   awready,
    input  fir_pkg::reg_addr_t     awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`FIR_DATA_W-1:0] wdata,
    input  logic                   arvalid,
    output logic                   arready,
    input  fir_pkg::reg_addr_t     araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`FIR_DATA_W-1:0] rdata,
    // ============================================================
    // sample in, result out
    // ============================================================
    input  logic                   ss_tvalid,
    output logic                   ss_tready,
    input  fir_pkg::sample_t       ss_tdata,
    input  logic                   ss_tlast,
    output logic                   sm_tvalid,
    input  logic                   sm_tready,
    output fir_pkg::acc_t          sm_tdata,
    output logic                   sm_tlast
);

    // control between stages
    logic              start;
    logic              run_done;
    fir_pkg::length_t  data_length;
    // coefficient and history lookups
    fir_pkg::coef_t    coef;
    fir_pkg::tap_idx_t tap_idx;
    logic              push;
    fir_pkg::sample_t  push_data;
    fir_pkg::sample_t  rd_data;

    fir_config_regs u_config_regs (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .run_done(run_done), .tap_idx(tap_idx), .start(start),
        .data_length(data_length), .coef(coef)
    );

    // history is cleared by the same start pulse
    fir_sample_ring u_sample_ring (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n), .clear(start),
        .push(push), .push_data(push_data), .rd_lag(tap_idx), .rd_data(rd_data)
    );

    fir_mac_engine u_mac_engine (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n), .start(start),
        .data_length(data_length), .coef(coef),
        .ss_tvalid(ss_tvalid), .ss_tready(ss_tready), .ss_tdata(ss_tdata),
        .ss_tlast(ss_tlast), .push(push), .push_data(push_data), .rd_data(rd_data),
        .tap_idx(tap_idx), .sm_tvalid(sm_tvalid), .sm_tready(sm_tready),
        .sm_tdata(sm_tdata), .sm_tlast(sm_tlast), .run_done(run_done)
    );

endmodule

/* test/fir_tb.sv */
`timescale 1ns/100ps
`include "fir_macros.svh"

module fir_tb;

    localparam int TIMEOUT_CYCLES = 60;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid;
    logic                   awready;
    fir_pkg::reg_addr_t     awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [`FIR_DATA_W-1:0] wdata;
    logic                   arvalid;
    logic                   arready;
    fir_pkg::reg_addr_t     araddr;
    logic                   rvalid;
    logic                   rready;
    logic [`FIR_DATA_W-1:0] rdata;
    logic                   ss_tvalid;
    logic                   ss_tready;
    fir_pkg::sample_t       ss_tdata;
    logic                   ss_tlast;
    logic                   sm_tvalid;
    logic                   sm_tready;
    fir_pkg::acc_t          sm_tdata;
    logic                   sm_tlast;

    // xorshift state, taps as written, model history (index 0 newest)
    logic [31:0]            rng_state;
    fir_pkg::coef_t         taps [`FIR_NUM_TAPS];
    fir_pkg::sample_t       model_hist [`FIR_NUM_TAPS];

    fir_tb_clock u_clock (.axis_clk(axis_clk), .axis_rst_n(axis_rst_n));

    fir_top u_fir_top (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .ss_tvalid(ss_tvalid), .ss_tready(ss_tready), .ss_tdata(ss_tdata),
        .ss_tlast(ss_tlast), .sm_tvalid(sm_tvalid), .sm_tready(sm_tready),
        .sm_tdata(sm_tdata), .sm_tlast(sm_tlast)
    );

    // ============================================================
    // helpers and checks
    // ============================================================

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic fir_pkg::reg_addr_t tap_addr(input int k);
        return fir_pkg::reg_addr_t'(`FIR_TAP_BASE + k * `FIR_TAP_STRIDE);
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_acc(input string name, input fir_pkg::acc_t exp_v,
                               input fir_pkg::acc_t act_v);
        if (act_v !== exp_v) fail_now($sformatf("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                                                $time, name, exp_v, act_v));
    endtask

    task automatic compare_coef(input string name, input fir_pkg::coef_t exp_v,
                                input fir_pkg::coef_t act_v);
        if (act_v !== exp_v) fail_now($sformatf("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                                                $time, name, exp_v, act_v));
    endtask

    task automatic compare_len(input string name, input fir_pkg::length_t exp_v,
                               input fir_pkg::length_t act_v);
        if (act_v !== exp_v) fail_now($sformatf("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                                                $time, name, exp_v, act_v));
    endtask

    // {idle, done, start}
    task automatic compare_status(input string name, input logic [2:0] exp_v,
                                  input logic [2:0] act_v);
        if (act_v !== exp_v) fail_now($sformatf("MISMATCH time=%0t signal=%s expected=%0b actual=%0b",
                                                $time, name, exp_v, act_v));
    endtask

    task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) fail_now($sformatf("MISMATCH time=%0t signal=%s expected=%0b actual=%0b",
                                                $time, name, exp_v, act_v));
    endtask

    // ============================================================
    // bus drivers
    // ============================================================

    task automatic reg_write(input fir_pkg::reg_addr_t addr, input logic [31:0] data);
        int waited;
        @(negedge axis_clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        waited  = 0;
        #1;
        while (!(awready && wready)) begin
            @(negedge axis_clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_now("register write never accepted by the DUT");
        end
        // taken on the rising edge in between
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic reg_read(input fir_pkg::reg_addr_t addr, output logic [31:0] data);
        int waited;
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = addr;
        waited  = 0;
        #1;
        while (!arready) begin
            @(negedge axis_clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_now("register read address never accepted");
        end
        @(negedge axis_clk);
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid) begin
            @(negedge axis_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_now("read data never became valid");
        end
        data   = rdata;
        rready = 1'b1;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic send_sample(input fir_pkg::sample_t s, input logic last);
        int waited;
        @(negedge axis_clk);
        ss_tvalid = 1'b1;
        ss_tdata  = s;
        ss_tlast  = last;
        waited    = 0;
        #1;
        while (!ss_tready) begin
            @(negedge axis_clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_now("input stream never became ready");
        end
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    // holds sm_tready low for stall cycles once the result shows up
    task automatic take_result(input int stall, output fir_pkg::acc_t data, output logic last);
        int waited;
        int i;
        waited = 0;
        while (!sm_tvalid) begin
            @(negedge axis_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_now("output stream never became valid");
        end
        data = sm_tdata;
        last = sm_tlast;
        for (i = 0; i < stall; i++) begin
            @(negedge axis_clk);
            compare_flag("sm_tvalid during stall", 1'b1, sm_tvalid);
            compare_acc("sm_tdata during stall", data, sm_tdata);
            compare_flag("ss_tready during stall", 1'b0, ss_tready);
        end
        sm_tready = 1'b1;
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    // ============================================================
    // reference model
    // ============================================================

    task automatic model_clear();
        int k;
        for (k = 0; k < `FIR_NUM_TAPS; k++) model_hist[k] = '0;
    endtask

    // y = sum of tap k times the sample k steps back, wrapped to 32 bits
    task automatic model_step(input fir_pkg::sample_t s, output fir_pkg::acc_t y);
        int k;
        fir_pkg::acc_t sum;
        for (k = `FIR_NUM_TAPS - 1; k > 0; k--) model_hist[k] = model_hist[k-1];
        model_hist[0] = s;
        sum = '0;
        for (k = 0; k < `FIR_NUM_TAPS; k++) sum = sum + fir_pkg::acc_t'(taps[k] * model_hist[k]);
        y = sum;
    endtask

    task automatic load_taps();
        int k;
        for (k = 0; k < `FIR_NUM_TAPS; k++) begin
            taps[k] = fir_pkg::coef_t'(next_random());
            reg_write(tap_addr(k), taps[k]);
        end
    endtask

    task automatic start_run();
        reg_write(`FIR_REG_CTRL, 32'h1);
        model_clear();
    endtask

    task automatic run_and_check(input int n, input logic impulse, input logic stalls);
        int i;
        int stall;
        fir_pkg::sample_t s;
        fir_pkg::acc_t exp_v;
        fir_pkg::acc_t got;
        logic got_last;
        for (i = 0; i < n; i++) begin
            s = impulse ? fir_pkg::sample_t'((i == 0) ? 1 : 0) : fir_pkg::sample_t'(next_random());
            model_step(s, exp_v);
            // impulse in, taps out in order
            if (impulse) exp_v = fir_pkg::acc_t'(taps[i]);
            stall = stalls ? int'(next_random() % 4) : 0;
            send_sample(s, i == n - 1);
            take_result(stall, got, got_last);
            compare_acc($sformatf("sm_tdata[%0d]", i), exp_v, got);
            compare_flag($sformatf("sm_tlast[%0d]", i), i == n - 1, got_last);
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================

    task automatic test_reset_state();
        logic [31:0] r;
        reg_read(`FIR_REG_CTRL, r);
        compare_status("ctrl status after reset", 3'b100, r[2:0]);
        compare_flag("ss_tready after reset", 1'b0, ss_tready);
        compare_flag("sm_tvalid after reset", 1'b0, sm_tvalid);
    endtask

    task automatic test_reg_readback();
        int k;
        logic [31:0] r;
        fir_pkg::length_t len;
        load_taps();
        len = fir_pkg::length_t'(next_random() % 64 + 1);
        reg_write(`FIR_REG_LEN, len);
        for (k = 0; k < `FIR_NUM_TAPS; k++) begin
            reg_read(tap_addr(k), r);
            compare_coef($sformatf("tap[%0d] readback", k), taps[k], fir_pkg::coef_t'(r));
        end
        reg_read(`FIR_REG_LEN, r);
        compare_len("data_length readback", len, fir_pkg::length_t'(r));
        reg_read(tap_addr(11), r);
        compare_coef("tap[11] readback", '0, fir_pkg::coef_t'(r));
        reg_read(12'h100, r);
        compare_len("unmapped 0x100 readback", '0, fir_pkg::length_t'(r));
    endtask

    task automatic test_impulse();
        load_taps();
        reg_write(`FIR_REG_LEN, 32'd11);
        start_run();
        run_and_check(11, 1'b1, 1'b0);
    endtask

    task automatic test_random_stream();
        reg_write(`FIR_REG_LEN, 32'd20);
        start_run();
        run_and_check(20, 1'b0, 1'b1);
    endtask

    // done survives one status read, then a fresh run from cleared history
    task automatic test_done_and_rerun();
        logic [31:0] r;
        reg_read(`FIR_REG_CTRL, r);
        compare_status("ctrl status after run", 3'b110, r[2:0]);
        reg_read(`FIR_REG_CTRL, r);
        compare_status("ctrl status second read", 3'b100, r[2:0]);
        start_run();
        run_and_check(20, 1'b0, 1'b1);
    endtask

    task automatic test_frozen_settings();
        logic [31:0] r;
        reg_write(`FIR_REG_LEN, 32'd6);
        start_run();
        // both writes land while busy
        reg_write(tap_addr(3), ~taps[3]);
        reg_write(`FIR_REG_LEN, 32'd2);
        run_and_check(6, 1'b0, 1'b1);
        reg_read(tap_addr(3), r);
        compare_coef("tap[3] after busy write", taps[3], fir_pkg::coef_t'(r));
        reg_read(`FIR_REG_LEN, r);
        compare_len("data_length after busy write", 32'd6, fir_pkg::length_t'(r));
    endtask

    initial begin
        int waited;
        rng_state = 32'h3b06_aef9;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        ss_tlast  = 1'b0;
        sm_tready = 1'b0;
        waited    = 0;
        while (axis_rst_n !== 1'b1) begin
            @(negedge axis_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_now("reset was never released");
        end
        test_reset_state();
        test_reg_readback();
        test_impulse();
        test_random_stream();
        test_done_and_rerun();
        test_frozen_settings();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* test/fir_tb_clock.sv */
`timescale 1ns/100ps

module fir_tb_clock (
    output logic axis_clk,
    output logic axis_rst_n
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        axis_clk = 1'b0;
        forever #50 axis_clk = ~axis_clk;
    end

    // ten cycles in reset, released on a falling edge
    initial begin
        axis_rst_n = 1'b0;
        repeat (10) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
    end

endmodule
